/* core_top.f */
hw/core_pkg.sv
hw/ifu.sv
hw/idu.sv
hw/exu.sv
hw/gpr.sv
hw/core_top.sv
testbench/axil_imem_model.sv
testbench/tb_core_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_core_top
FLIST     ?= core_top.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o sim
	./$(OBJ_DIR)/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_core_top.sv */
module tb_core_top;

    timeunit 1ns;
    timeprecision 100ps;

    logic               clk = 1'b0;
    logic               reset_i;
    core_pkg::axil_ar_t m_ar;
    logic               m_arready;
    core_pkg::axil_r_t  m_r;
    logic               m_rready;
    core_pkg::retire_t  retire;
    logic               delay_en;
    logic [2:0]         ar_wait;
    logic [2:0]         r_wait;
    core_pkg::word_t    err_word;
    core_pkg::word_t    rng = 32'h39162e44;
    core_pkg::word_t    dly_state = 32'h39162e44;
    core_pkg::word_t    reg_a;
    core_pkg::word_t    reg_b;
    core_pkg::word_t    pc_b;
    core_pkg::word_t    exp_x [32];
    core_pkg::retire_t  exp_q [$];
    int                 err_count = 0;
    int                 check_count = 0;
    int                 tests_run = 0;

    core_top i_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .m_ar_o     (m_ar),
        .m_arready_i(m_arready),
        .m_r_i      (m_r),
        .m_rready_o (m_rready),
        .retire_o   (retire)
    );

    axil_imem_model u_imem (
        .clk       (clk),
        .reset_i   (reset_i),
        .ar_i      (m_ar),
        .arready_o (m_arready),
        .r_o       (m_r),
        .rready_i  (m_rready),
        .ar_wait_i (ar_wait),
        .r_wait_i  (r_wait),
        .err_word_i(err_word)
    );

    always #10 clk = ~clk;

    function automatic core_pkg::word_t xorshift(input core_pkg::word_t s);
        core_pkg::word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic core_pkg::word_t rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // bus delays come from their own stream
    always @(posedge clk) begin
        dly_state <= xorshift(dly_state);
        ar_wait   <= delay_en ? dly_state[2:0] : 3'd0;
        r_wait    <= delay_en ? dly_state[5:3] : 3'd0;
    end

    function automatic core_pkg::word_t sext(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic core_pkg::word_t enc_i(input logic [11:0] imm, input core_pkg::reg_idx_t rs1,
                                              input logic [2:0] f3, input core_pkg::reg_idx_t rd,
                                              input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic core_pkg::word_t enc_r(input logic [6:0] f7, input core_pkg::reg_idx_t rs2,
                                              input core_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                              input core_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::word_t enc_u(input logic [19:0] imm, input core_pkg::reg_idx_t rd,
                                              input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic core_pkg::word_t enc_b(input logic [12:0] imm, input core_pkg::reg_idx_t rs2,
                                              input core_pkg::reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic core_pkg::word_t enc_j(input logic [20:0] imm, input core_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // branch outcome per the RV32I compare rules
    function automatic logic br_taken(input logic [2:0] f3, input core_pkg::word_t a,
                                      input core_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check(input string name, input string field, input core_pkg::word_t exp,
                         input core_pkg::word_t act);
        check_count++;
        if (exp !== act) begin
            $display("mismatch %s %s: expected %h actual %h", name, field, exp, act);
            err_count++;
        end
    endtask

    task automatic place(input core_pkg::word_t instr);
        u_imem.mem[pc_b[9:2]] = instr;
        pc_b = pc_b + 32'd4;
    endtask

    task automatic push(input core_pkg::word_t pc, input core_pkg::word_t instr, input logic we,
                        input core_pkg::word_t data, input logic ill);
        core_pkg::retire_t rec;
        rec.valid   = 1'b1;
        rec.pc      = pc;
        rec.rd      = instr[11:7];
        rec.wr_en   = we;
        rec.wr_data = data;
        rec.illegal = ill;
        exp_q.push_back(rec);
    endtask

    // place an instruction that writes rd, and track the expected register
    task automatic put_wr(input core_pkg::word_t instr, input core_pkg::word_t data);
        push(pc_b, instr, instr[11:7] != 5'd0, data, 1'b0);
        if (instr[11:7] != 5'd0) begin
            exp_x[instr[11:7]] = data;
        end
        place(instr);
    endtask

    task automatic start_test();
        @(posedge clk);
        reset_i <= 1'b1;
        // addi x0 with the word index as immediate
        for (int i = 0; i < 256; i++) begin
            u_imem.mem[i] = {4'b0, i[7:0], 20'h00013};
        end
        for (int i = 0; i < 32; i++) begin
            exp_x[i] = '0;
        end
        exp_q.delete();
        pc_b     = core_pkg::reset_pc;
        err_word = '1;
    endtask

    task automatic run_prog(input string name);
        core_pkg::retire_t exp;
        core_pkg::retire_t got;
        int                errs0;
        int                n;
        errs0 = err_count;
        n     = 0;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            // fetches are unprivileged data reads
            if (m_ar.arvalid) begin
                check(name, "arprot", 32'd0, {29'b0, m_ar.arprot});
            end
            if (retire.valid) begin
                got = retire;
                exp = exp_q.pop_front();
                n++;
                check(name, "pc", exp.pc, got.pc);
                check(name, "rd", {27'b0, exp.rd}, {27'b0, got.rd});
                check(name, "wr_en", {31'b0, exp.wr_en}, {31'b0, got.wr_en});
                if (exp.wr_en) begin
                    check(name, "wr_data", exp.wr_data, got.wr_data);
                end
                check(name, "illegal", {31'b0, exp.illegal}, {31'b0, got.illegal});
            end
        end
        tests_run++;
        $display("test %s: %0d retired, %0d errors", name, n, err_count - errs0);
    endtask

    task automatic imm_alu_test();
        core_pkg::word_t r;
        core_pkg::word_t a;
        core_pkg::word_t b;
        logic [11:0]     k;
        logic [4:0]      sh;
        start_test();
        r = rand32();
        // negative sources so signed and unsigned results differ
        put_wr(enc_i({1'b1, r[10:0]}, 0, 3'b000, 1, core_pkg::OP_IMM), sext({1'b1, r[10:0]}));
        put_wr(enc_i({1'b1, r[22:12]}, 0, 3'b000, 2, core_pkg::OP_IMM), sext({1'b1, r[22:12]}));
        r  = rand32();
        k  = r[11:0];
        sh = r[16:12];
        a  = exp_x[1];
        b  = sext(k);
        put_wr(enc_i(k, 1, 3'b010, 3, core_pkg::OP_IMM), {31'b0, $signed(a) < $signed(b)});
        put_wr(enc_i(k, 2, 3'b011, 4, core_pkg::OP_IMM), {31'b0, exp_x[2] < b});
        put_wr(enc_i(k, 1, 3'b100, 5, core_pkg::OP_IMM), a ^ b);
        put_wr(enc_i(k, 1, 3'b110, 6, core_pkg::OP_IMM), a | b);
        put_wr(enc_i(k, 1, 3'b111, 7, core_pkg::OP_IMM), a & b);
        put_wr(enc_i({7'h00, sh}, 1, 3'b001, 8, core_pkg::OP_IMM), a << sh);
        put_wr(enc_i({7'h00, sh}, 1, 3'b101, 9, core_pkg::OP_IMM), a >> sh);
        put_wr(enc_i({7'h20, sh}, 1, 3'b101, 10, core_pkg::OP_IMM), $signed(a) >>> sh);
        run_prog("imm_alu");
    endtask

    // lui then addi, with the carry from imm bit 11 folded into the upper part
    task automatic load_const(input core_pkg::reg_idx_t rd, input core_pkg::word_t v);
        logic [19:0] hi;
        hi = v[31:12] + {19'b0, v[11]};
        put_wr(enc_u(hi, rd, core_pkg::LUI), {hi, 12'b0});
        put_wr(enc_i(v[11:0], rd, 3'b000, rd, core_pkg::OP_IMM), {hi, 12'b0} + sext(v[11:0]));
    endtask

    task automatic reg_alu_test(input string name);
        core_pkg::word_t a;
        core_pkg::word_t b;
        start_test();
        a = reg_a;
        b = reg_b;
        load_const(1, a);
        load_const(2, b);
        put_wr(enc_r(7'h00, 2, 1, 3'b000, 3), a + b);
        put_wr(enc_r(7'h20, 2, 1, 3'b000, 4), a - b);
        put_wr(enc_r(7'h00, 2, 1, 3'b001, 5), a << b[4:0]);
        put_wr(enc_r(7'h00, 2, 1, 3'b010, 6), {31'b0, $signed(a) < $signed(b)});
        put_wr(enc_r(7'h00, 2, 1, 3'b011, 7), {31'b0, a < b});
        put_wr(enc_r(7'h00, 2, 1, 3'b100, 8), a ^ b);
        put_wr(enc_r(7'h00, 2, 1, 3'b101, 9), a >> b[4:0]);
        put_wr(enc_r(7'h20, 2, 1, 3'b101, 10), $signed(a) >>> b[4:0]);
        put_wr(enc_r(7'h00, 2, 1, 3'b110, 11), a | b);
        put_wr(enc_r(7'h00, 2, 1, 3'b111, 12), a & b);
        // zero minus x2 wraps around
        put_wr(enc_r(7'h20, 2, 0, 3'b000, 13), 32'd0 - b);
        run_prog(name);
    endtask

    task automatic upper_test();
        core_pkg::word_t r;
        core_pkg::word_t s;
        start_test();
        r = rand32();
        s = rand32();
        put_wr(enc_u(r[31:12], 5, core_pkg::LUI), {r[31:12], 12'b0});
        put_wr(enc_u(s[31:12], 6, core_pkg::AUIPC), pc_b + {s[31:12], 12'b0});
        put_wr(enc_i(r[11:0], 0, 3'b000, 0, core_pkg::OP_IMM), sext(r[11:0]));
        put_wr(enc_r(7'h00, 5, 0, 3'b000, 7), exp_x[5]);
        put_wr(enc_r(7'h00, 0, 0, 3'b110, 8), 32'd0);
        run_prog("upper_x0");
    endtask

    // taken branches skip the marker addi at pc + 4
    task automatic branch(input logic [2:0] f3, input core_pkg::reg_idx_t rs1,
                          input core_pkg::reg_idx_t rs2);
        core_pkg::word_t instr;
        instr = enc_b(13'd8, rs2, rs1, f3);
        push(pc_b, instr, 1'b0, '0, 1'b0);
        place(instr);
        if (br_taken(f3, exp_x[rs1], exp_x[rs2])) begin
            place(enc_i(12'd1, 0, 3'b000, 31, core_pkg::OP_IMM));
        end else begin
            put_wr(enc_i(12'd1, 20, 3'b000, 20, core_pkg::OP_IMM), exp_x[20] + 32'd1);
        end
    endtask

    task automatic control_test();
        logic [2:0] codes [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        start_test();
        put_wr(enc_i(12'hffb, 0, 3'b000, 1, core_pkg::OP_IMM), 32'hffff_fffb);
        put_wr(enc_i(12'd3, 0, 3'b000, 2, core_pkg::OP_IMM), 32'd3);
        for (int j = 0; j < 6; j++) begin
            branch(codes[j], 1, 2);
            branch(codes[j], 2, 1);
            branch(codes[j], 1, 1);
        end
        put_wr(enc_j(21'd12, 3), pc_b + 32'd4);
        place(enc_i(12'd1, 0, 3'b000, 31, core_pkg::OP_IMM));
        place(enc_i(12'd2, 0, 3'b000, 31, core_pkg::OP_IMM));
        put_wr(enc_u(20'd0, 4, core_pkg::AUIPC), pc_b);
        // odd offset, target lands on the word after the skipped one
        put_wr(enc_i(12'd13, 4, 3'b000, 5, core_pkg::JALR), pc_b + 32'd4);
        place(enc_i(12'd3, 0, 3'b000, 31, core_pkg::OP_IMM));
        put_wr(enc_i(12'd7, 0, 3'b000, 6, core_pkg::OP_IMM), 32'd7);
        run_prog("control_flow");
    endtask

    task automatic illegal_test();
        core_pkg::word_t instr;
        start_test();
        put_wr(enc_i(12'd9, 0, 3'b000, 1, core_pkg::OP_IMM), 32'd9);
        // custom-0 opcode, not decoded by this core
        instr = 32'h0000_018b;
        push(pc_b, instr, 1'b0, '0, 1'b1);
        place(instr);
        instr    = enc_i(12'd5, 0, 3'b000, 2, core_pkg::OP_IMM);
        err_word = pc_b >> 2;
        push(pc_b, instr, 1'b0, '0, 1'b1);
        place(instr);
        put_wr(enc_i(12'd1, 1, 3'b000, 4, core_pkg::OP_IMM), 32'd10);
        run_prog("illegal");
    endtask

    // 82 instructions retire over all tests, 16 cycles of 20 ns each
    initial begin
        #(82 * 16 * 20);
        $display("watchdog timeout, the core stopped retiring instructions");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        reset_i  = 1'b1;
        delay_en = 1'b0;
        err_word = '1;
        ar_wait  = 3'd0;
        r_wait   = 3'd0;
        reg_a    = rand32() | 32'h8000_0000;
        reg_b    = rand32();
        imm_alu_test();
        reg_alu_test("reg_alu");
        upper_test();
        control_test();
        illegal_test();
        delay_en = 1'b1;
        reg_alu_test("reg_alu_delayed");
        delay_en = 1'b0;
        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* testbench/axil_imem_model.sv */
module axil_imem_model (
    input  logic               clk,
    input  logic               reset_i,
    input  core_pkg::axil_ar_t ar_i,
    output logic               arready_o,
    output core_pkg::axil_r_t  r_o,
    input  logic               rready_i,
    input  logic [2:0]         ar_wait_i,
    input  logic [2:0]         r_wait_i,
    input  core_pkg::word_t    err_word_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // 1 KiB of instruction words, indexed by address bits 9:2
    core_pkg::word_t mem [256];

    logic            busy_q;
    logic [2:0]      cnt_q;
    core_pkg::word_t addr_q;

    initial begin
        arready_o = 1'b0;
        r_o       = '0;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            arready_o <= 1'b0;
            r_o       <= '0;
            busy_q    <= 1'b0;
            cnt_q     <= 3'd0;
            addr_q    <= '0;
        end else begin
            arready_o <= 1'b0;
            if (!busy_q) begin
                if (ar_i.arvalid && arready_o) begin
                    // address accepted, count down to the data beat
                    busy_q <= 1'b1;
                    addr_q <= ar_i.araddr;
                    cnt_q  <= r_wait_i;
                end else if (ar_i.arvalid) begin
                    if (cnt_q == 3'd0) begin
                        arready_o <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q - 3'd1;
                    end
                end
            end else if (r_o.rvalid) begin
                if (rready_i) begin
                    r_o.rvalid <= 1'b0;
                    busy_q     <= 1'b0;
                    cnt_q      <= ar_wait_i;
                end
            end else if (cnt_q == 3'd0) begin
                r_o.rvalid <= 1'b1;
                r_o.rdata  <= mem[addr_q[9:2]];
                // SLVERR on the one selected word
                r_o.rresp  <= (addr_q[31:2] == err_word_i[29:0]) ? 2'b10 : 2'b00;
            end else begin
                cnt_q <= cnt_q - 3'd1;
            end
        end
    end

endmodule

/* hw/core_top.sv */
module core_top (
    input  logic               clk,
    input  logic               reset_i,
    output core_pkg::axil_ar_t m_ar_o,
    input  logic               m_arready_i,
    input  core_pkg::axil_r_t  m_r_i,
    output logic               m_rready_o,
    output core_pkg::retire_t  retire_o
);

    core_pkg::fetch_t    fetch;
    core_pkg::decode_t   decode;
    core_pkg::redirect_t redirect;
    core_pkg::reg_idx_t  rs1_idx;
    core_pkg::reg_idx_t  rs2_idx;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    logic                wr_en;
    core_pkg::reg_idx_t  wr_idx;
    core_pkg::word_t     wr_data;

    ifu u_ifu (
        .clk        (clk),
        .reset_i    (reset_i),
        .redirect_i (redirect),
        .m_ar_o     (m_ar_o),
        .m_arready_i(m_arready_i),
        .m_r_i      (m_r_i),
        .m_rready_o (m_rready_o),
        .fetch_o    (fetch)
    );

    idu u_idu (
        .clk     (clk),
        .reset_i (reset_i),
        .fetch_i (fetch),
        .rs1_o   (rs1_idx),
        .rs2_o   (rs2_idx),
        .decode_o(decode)
    );

    gpr u_gpr (
        .clk       (clk),
        .reset_i   (reset_i),
        .rs1_i     (rs1_idx),
        .rs2_i     (rs2_idx),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data)
    );

    exu u_exu (
        .clk       (clk),
        .reset_i   (reset_i),
        .decode_i  (decode),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .wr_en_o   (wr_en),
        .wr_idx_o  (wr_idx),
        .wr_data_o (wr_data),
        .redirect_o(redirect),
        .retire_o  (retire_o)
    );

endmodule

/* hw/gpr.sv */
module gpr (
    input  logic               clk,
    input  logic               reset_i,
    input  core_pkg::reg_idx_t rs1_i,
    input  core_pkg::reg_idx_t rs2_i,
    output core_pkg::word_t    rs1_data_o,
    output core_pkg::word_t    rs2_data_o,
    input  logic               wr_en_i,
    input  core_pkg::reg_idx_t wr_idx_i,
    input  core_pkg::word_t    wr_data_i
);

    core_pkg::word_t regs_q [2**core_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 2**core_pkg::reg_addr_w; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            // x0 is never written
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    // asynchronous reads, x0 reads as zero
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* hw/exu.sv */
module exu (
    input  logic                clk,
    input  logic                reset_i,
    input  core_pkg::decode_t   decode_i,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    output logic                wr_en_o,
    output core_pkg::reg_idx_t  wr_idx_o,
    output core_pkg::word_t     wr_data_o,
    output core_pkg::redirect_t redirect_o,
    output core_pkg::retire_t   retire_o
);

    core_pkg::word_t     op_a;
    core_pkg::word_t     op_b;
    core_pkg::word_t     alu_res;
    core_pkg::word_t     pc_plus4;
    core_pkg::word_t     target;
    logic                is_jump;
    logic                br_cond;
    logic                taken;
    core_pkg::retire_t   retire_q;
    core_pkg::redirect_t redirect_q;

    assign op_a     = decode_i.pc_a ? decode_i.pc : rs1_data_i;
    assign op_b     = decode_i.use_imm ? decode_i.imm : rs2_data_i;
    assign pc_plus4 = decode_i.pc + 32'd4;

    always_comb begin
        case (decode_i.alu_op)
            core_pkg::ALU_ADD:    alu_res = op_a + op_b;
            core_pkg::ALU_SUB:    alu_res = op_a - op_b;
            core_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
            core_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            core_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
            core_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            core_pkg::ALU_OR:     alu_res = op_a | op_b;
            core_pkg::ALU_AND:    alu_res = op_a & op_b;
            core_pkg::ALU_PASS_B: alu_res = op_b;
            default:              alu_res = '0;
        endcase
    end

    // comparator always sees the register operands
    always_comb begin
        case (decode_i.funct3)
            core_pkg::f3_beq:  br_cond = (rs1_data_i == rs2_data_i);
            core_pkg::f3_bne:  br_cond = (rs1_data_i != rs2_data_i);
            core_pkg::f3_blt:  br_cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            core_pkg::f3_bge:  br_cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            core_pkg::f3_bltu: br_cond = (rs1_data_i < rs2_data_i);
            core_pkg::f3_bgeu: br_cond = (rs1_data_i >= rs2_data_i);
            default:           br_cond = 1'b0;
        endcase
    end

    assign is_jump = (decode_i.kind == core_pkg::KIND_JAL) ||
                     (decode_i.kind == core_pkg::KIND_JALR);
    assign taken   = is_jump || ((decode_i.kind == core_pkg::KIND_BRANCH) && br_cond);
    // jalr target has bit 0 cleared
    assign target  = (decode_i.kind == core_pkg::KIND_JALR) ? {alu_res[31:1], 1'b0} : alu_res;

    // write-back lands on the same edge as the retire record
    assign wr_en_o   = decode_i.valid && decode_i.wr_en;
    assign wr_idx_o  = decode_i.rd;
    assign wr_data_o = is_jump ? pc_plus4 : alu_res;

    always_ff @(posedge clk) begin
        retire_q.pc      <= decode_i.pc;
        retire_q.rd      <= decode_i.rd;
        retire_q.wr_en   <= decode_i.wr_en;
        retire_q.wr_data <= wr_data_o;
        retire_q.illegal <= (decode_i.kind == core_pkg::KIND_ILLEGAL);
        redirect_q.pc    <= taken ? target : pc_plus4;
        if (reset_i) begin
            retire_q.valid   <= 1'b0;
            redirect_q.valid <= 1'b0;
        end else begin
            retire_q.valid   <= decode_i.valid;
            redirect_q.valid <= decode_i.valid;
        end
    end

    assign retire_o   = retire_q;
    assign redirect_o = redirect_q;

endmodule

/* hw/idu.sv */
module idu (
    input  logic               clk,
    input  logic               reset_i,
    input  core_pkg::fetch_t   fetch_i,
    output core_pkg::reg_idx_t rs1_o,
    output core_pkg::reg_idx_t rs2_o,
    output core_pkg::decode_t  decode_o
);

    core_pkg::opcode_e opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    core_pkg::word_t   imm_i;
    core_pkg::word_t   imm_u;
    core_pkg::word_t   imm_b;
    core_pkg::word_t   imm_j;
    logic              legal;
    core_pkg::decode_t dec_d;
    core_pkg::decode_t dec_q;

    // funct3 to alu op, alt is instr bit 30
    function automatic core_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt,
                                                    input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  return core_pkg::ALU_SLL;
            3'b010:  return core_pkg::ALU_SLT;
            3'b011:  return core_pkg::ALU_SLTU;
            3'b100:  return core_pkg::ALU_XOR;
            3'b101:  return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  return core_pkg::ALU_OR;
            default: return core_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = core_pkg::opcode_e'(fetch_i.instr[6:0]);
    assign funct3 = fetch_i.instr[14:12];
    assign funct7 = fetch_i.instr[31:25];

    assign imm_i = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
    assign imm_u = {fetch_i.instr[31:12], 12'b0};
    assign imm_b = {{19{fetch_i.instr[31]}}, fetch_i.instr[31], fetch_i.instr[7],
                    fetch_i.instr[30:25], fetch_i.instr[11:8], 1'b0};
    assign imm_j = {{11{fetch_i.instr[31]}}, fetch_i.instr[31], fetch_i.instr[19:12],
                    fetch_i.instr[20], fetch_i.instr[30:21], 1'b0};

    always_comb begin
        dec_d.valid   = fetch_i.valid;
        dec_d.pc      = fetch_i.pc;
        dec_d.kind    = core_pkg::KIND_ALU;
        dec_d.alu_op  = core_pkg::ALU_ADD;
        dec_d.funct3  = funct3;
        dec_d.rs1     = fetch_i.instr[19:15];
        dec_d.rs2     = fetch_i.instr[24:20];
        dec_d.rd      = fetch_i.instr[11:7];
        dec_d.imm     = imm_i;
        dec_d.use_imm = 1'b1;
        dec_d.pc_a    = 1'b0;
        dec_d.wr_en   = 1'b1;
        legal         = 1'b1;
        case (opcode)
            core_pkg::OP_IMM: begin
                dec_d.alu_op = f3_to_alu(funct3, funct7[5], 1'b0);
                // shift amounts carry funct7 in the upper immediate bits
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            core_pkg::OP: begin
                dec_d.use_imm = 1'b0;
                dec_d.alu_op  = f3_to_alu(funct3, funct7[5], 1'b1);
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            core_pkg::LUI: begin
                dec_d.imm    = imm_u;
                dec_d.alu_op = core_pkg::ALU_PASS_B;
            end
            core_pkg::AUIPC: begin
                dec_d.imm  = imm_u;
                dec_d.pc_a = 1'b1;
            end
            core_pkg::JAL: begin
                dec_d.kind = core_pkg::KIND_JAL;
                dec_d.imm  = imm_j;
                dec_d.pc_a = 1'b1;
            end
            core_pkg::JALR: begin
                dec_d.kind = core_pkg::KIND_JALR;
                legal      = (funct3 == 3'b000);
            end
            core_pkg::BRANCH: begin
                // alu forms pc + offset, rs1 and rs2 go to the comparator
                dec_d.kind  = core_pkg::KIND_BRANCH;
                dec_d.imm   = imm_b;
                dec_d.pc_a  = 1'b1;
                dec_d.wr_en = 1'b0;
                legal       = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        if (!legal || fetch_i.err) begin
            dec_d.kind  = core_pkg::KIND_ILLEGAL;
            dec_d.wr_en = 1'b0;
        end
        if (dec_d.rd == '0) begin
            dec_d.wr_en = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q <= dec_d;
        end
    end

    // register file reads follow the registered decode
    assign rs1_o    = dec_q.rs1;
    assign rs2_o    = dec_q.rs2;
    assign decode_o = dec_q;

endmodule

/* hw/ifu.sv */
module ifu (
    input  logic                clk,
    input  logic                reset_i,
    input  core_pkg::redirect_t redirect_i,
    output core_pkg::axil_ar_t  m_ar_o,
    input  logic                m_arready_i,
    input  core_pkg::axil_r_t   m_r_i,
    output logic                m_rready_o,
    output core_pkg::fetch_t    fetch_o
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } fetch_state_e;

    fetch_state_e     state_q;
    core_pkg::word_t  pc_q;
    logic             start_q;
    logic             r_done;
    core_pkg::fetch_t fetch_q;

    // R handshake ends the bus part of a fetch
    assign r_done = (state_q == DATA) && m_r_i.rvalid;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            pc_q    <= core_pkg::reset_pc;
            start_q <= 1'b1;
        end else begin
            case (state_q)
                IDLE: begin
                    // execute hands back the next pc once per instruction
                    if (redirect_i.valid) begin
                        pc_q    <= redirect_i.pc;
                        state_q <= ADDR;
                    end else if (start_q) begin
                        start_q <= 1'b0;
                        state_q <= ADDR;
                    end
                end
                ADDR: begin
                    if (m_arready_i) begin
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (m_r_i.rvalid) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_done) begin
            fetch_q.pc    <= pc_q;
            fetch_q.instr <= m_r_i.rdata;
            // SLVERR or DECERR turns into an illegal instruction downstream
            fetch_q.err   <= (m_r_i.rresp != core_pkg::axi_resp_okay);
        end
        if (reset_i) begin
            fetch_q.valid <= 1'b0;
        end else begin
            fetch_q.valid <= r_done;
        end
    end

    // word aligned read, unprivileged data access
    assign m_ar_o.arvalid = (state_q == ADDR);
    assign m_ar_o.araddr  = {pc_q[core_pkg::xlen-1:2], 2'b00};
    assign m_ar_o.arprot  = 3'b000;
    assign m_rready_o     = (state_q == DATA);
    assign fetch_o        = fetch_q;

endmodule

/* hw/core_pkg.sv */
package core_pkg;

    // fixed by the RV32I ISA
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    localparam logic [1:0] axi_resp_okay = 2'b00;

    // branch funct3 codes
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_ILLEGAL
    } instr_kind_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
        logic  err;
    } fetch_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        instr_kind_e kind;
        alu_op_e     alu_op;
        logic [2:0]  funct3;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;
        word_t       imm;
        logic        use_imm;
        logic        pc_a;
        logic        wr_en;
    } decode_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     wr_en;
        word_t    wr_data;
        logic     illegal;
    } retire_t;

    // AXI4-Lite read address, master side
    typedef struct packed {
        logic       arvalid;
        word_t      araddr;
        logic [2:0] arprot;
    } axil_ar_t;

    // AXI4-Lite read data, slave side
    typedef struct packed {
        logic       rvalid;
        word_t      rdata;
        logic [1:0] rresp;
    } axil_r_t;

endpackage
